//--- sources.f
common/rcd_pkg.sv
common/ca_if.sv
rcd/rcd_ctrl_words.sv
rcd/rcd_parity_check.sv
rcd/rcd_side_driver.sv
hdl/rdimm_rcd_top.sv
testbench/rcd_assert.sv
testbench/tb_rdimm_rcd.sv

//--- Makefile
# Verilator build and run for the rdimm rcd testbench

VERILATOR ?= verilator
TOP       ?= tb_rdimm_rcd
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failures, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_rdimm_rcd.sv
// rdimm rcd testbench
`timescale 1ns/10ps
`default_nettype none

module tb_rdimm_rcd;
  import rcd_pkg::*;

  localparam int CS_NUM = 2;

  // same field order as one side of the output bus
  typedef struct packed {
    logic              act_n;
    logic [ADDR_W-1:0] addr;
    logic [BA_W-1:0]   ba;
    logic [BG_W-1:0]   bg;
    logic              par;
    logic [CKE_W-1:0]  cke;
    logic [ODT_W-1:0]  odt;
    logic [CS_NUM-1:0] cs_n;
  } cmd_t;

  logic ck_t, rst_n, act_n, par, cw_we;
  logic [ADDR_W-1:0] addr;
  logic [BA_W-1:0] ba;
  logic [BG_W-1:0] bg;
  logic [CKE_W-1:0] cke;
  logic [ODT_W-1:0] odt;
  logic [CS_NUM-1:0] cs_n;
  logic [CW_ADDR_W-1:0] cw_addr;
  logic [CW_DATA_W-1:0] cw_data;
  logic qa_act_n, qa_par, qb_act_n, qb_par, alert_n;
  logic [ADDR_W-1:0] qa_addr, qb_addr;
  logic [BA_W-1:0] qa_ba, qb_ba;
  logic [BG_W-1:0] qa_bg, qb_bg;
  logic [CKE_W-1:0] qa_cke, qb_cke;
  logic [ODT_W-1:0] qa_odt, qb_odt;
  logic [CS_NUM-1:0] qa_cs_n, qb_cs_n;
  logic [CNT_W-1:0] par_err_cnt;

  cmd_t             idle;      // deselect with fields zero
  cmd_t             exp_a;     // predicted side a after next edge
  cmd_t             exp_b;
  cmd_t             c;
  logic             exp_alert;
  logic [CNT_W-1:0] exp_cnt;
  rcd_cfg_t         m_cfg;     // model copy of rc0/rc1
  int               errors, checks, tests, test_err0;

  rdimm_rcd_top #(.CS_NUM(CS_NUM)) dut_i (.*);

  always #5 ck_t = ~ck_t;

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_ba(input string name, input logic [BA_W-1:0] got,
                          input logic [BA_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_bg(input string name, input logic [BG_W-1:0] got,
                          input logic [BG_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_cke(input string name, input logic [CKE_W-1:0] got,
                           input logic [CKE_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_odt(input string name, input logic [ODT_W-1:0] got,
                           input logic [ODT_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_cs(input string name, input logic [CS_NUM-1:0] got,
                          input logic [CS_NUM-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_cnt(input string name, input logic [CNT_W-1:0] got,
                           input logic [CNT_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_side(input string s, input cmd_t got, input cmd_t exp);
    check_bit({s, "_act_n"}, got.act_n, exp.act_n);
    check_addr({s, "_addr"}, got.addr, exp.addr);
    check_ba({s, "_ba"}, got.ba, exp.ba);
    check_bg({s, "_bg"}, got.bg, exp.bg);
    check_bit({s, "_par"}, got.par, exp.par);
    check_cke({s, "_cke"}, got.cke, exp.cke);
    check_odt({s, "_odt"}, got.odt, exp.odt);
    check_cs({s, "_cs_n"}, got.cs_n, exp.cs_n);
  endtask

  task automatic check_outputs();
    check_side("qa", cmd_t'({qa_act_n, qa_addr, qa_ba, qa_bg, qa_par, qa_cke, qa_odt,
                             qa_cs_n}), exp_a);
    check_side("qb", cmd_t'({qb_act_n, qb_addr, qb_ba, qb_bg, qb_par, qb_cke, qb_odt,
                             qb_cs_n}), exp_b);
    check_bit("alert_n", alert_n, exp_alert);
    check_cnt("par_err_cnt", par_err_cnt, exp_cnt);
  endtask

  // par value that makes the total bit count even
  function automatic logic good_par(input cmd_t cmd);
    return ^{cmd.act_n, cmd.addr, cmd.ba, cmd.bg};
  endfunction

  function automatic logic [ADDR_W-1:0] mirror_addr(input logic [ADDR_W-1:0] a);
    int                lo [4];
    int                hi [4];
    logic [ADDR_W-1:0] m;
    lo = '{3, 5, 7, 11};  // swapped address pairs
    hi = '{4, 6, 8, 13};
    m = a;
    for (int i = 0; i < 4; i++)
    begin
      m[lo[i]] = a[hi[i]];
      m[hi[i]] = a[lo[i]];
    end
    return m;
  endfunction

  function automatic cmd_t rand_cmd();
    logic [31:0] r;
    cmd_t        cmd;
    r = $urandom();
    cmd = r[$bits(cmd_t)-1:0];  // random cs_n gives about a quarter idle
    cmd.par = good_par(cmd);
    return cmd;
  endfunction

  // outputs expected one edge after the command is sampled
  task automatic predict(input cmd_t cmd);
    logic err;
    err = m_cfg.par_en && !(&cmd.cs_n) && (cmd.par != good_par(cmd));
    exp_a = cmd;
    exp_b = cmd;
    if (m_cfg.mirror_en)
    begin
      exp_b.addr = mirror_addr(cmd.addr);
      exp_b.ba   = {cmd.ba[0], cmd.ba[1]};
      exp_b.bg   = {cmd.bg[0], cmd.bg[1]};
    end
    if (err || m_cfg.a_dis)
    begin
      exp_a.act_n = 1'b1;
      exp_a.cs_n  = '1;
    end
    if (err || m_cfg.b_dis)
    begin
      exp_b.act_n = 1'b1;
      exp_b.cs_n  = '1;
    end
    exp_alert = !err;
    if (err && exp_cnt != '1)
      exp_cnt = exp_cnt + 1'b1;
  endtask

  task automatic write_model(input logic [CW_ADDR_W-1:0] wa, input logic [CW_DATA_W-1:0] wd);
    if (wa == RC0_ADDR)
    begin
      m_cfg.par_en    = wd[0];
      m_cfg.mirror_en = wd[1];
    end
    else if (wa == RC1_ADDR)
    begin
      m_cfg.a_dis = wd[0];
      m_cfg.b_dis = wd[1];
    end
  endtask

  // drive on the rising edge then check the previous command at the falling edge
  task automatic step(input cmd_t cmd, input logic we, input logic [CW_ADDR_W-1:0] wa,
                      input logic [CW_DATA_W-1:0] wd);
    @(posedge ck_t);
    act_n   <= cmd.act_n;
    addr    <= cmd.addr;
    ba      <= cmd.ba;
    bg      <= cmd.bg;
    par     <= cmd.par;
    cke     <= cmd.cke;
    odt     <= cmd.odt;
    cs_n    <= cmd.cs_n;
    cw_we   <= we;
    cw_addr <= wa;
    cw_data <= wd;
    @(negedge ck_t);
    check_outputs();
    predict(cmd);                  // old config for this command
    if (we)
      write_model(wa, wd);
  endtask

  task automatic cmd_step(input cmd_t cmd);
    step(cmd, 1'b0, '0, '0);
  endtask

  task automatic write_cw(input logic [CW_ADDR_W-1:0] wa, input logic [CW_DATA_W-1:0] wd);
    step(idle, 1'b1, wa, wd);
  endtask

  task automatic wait_reset_state();
    int n;
    n = 0;
    while ((qa_cs_n !== '1 || qb_cs_n !== '1 || alert_n !== 1'b1) && n < 8)
    begin
      @(negedge ck_t);
      n++;
    end
    if (n >= 8)
    begin
      errors++;
      $display("timeout: outputs never reached their reset values");
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %0d %-14s %s, %0d errors", tests, name,
             (errors == test_err0) ? "ok" : "FAILED", errors - test_err0);
    test_err0 = errors;
  endtask

  // bad commands always followed by a good one
  task automatic bad_pair(input logic valid);
    c = rand_cmd();
    c.cs_n = valid ? {{(CS_NUM-1){1'b1}}, 1'b0} : {CS_NUM{1'b1}};
    c.par = ~c.par;
    cmd_step(c);
    cmd_step(rand_cmd());
  endtask

  initial
  begin
    void'($urandom(32'ha838));
    idle = '0;
    idle.act_n = 1'b1;
    idle.cs_n = '1;
    ck_t = 1'b0;
    rst_n = 1'b0;
    {act_n, addr, ba, bg, par, cke, odt, cs_n} = idle;
    cw_we = 1'b0;
    cw_addr = '0;
    cw_data = '0;
    m_cfg.par_en = 1'b1;           // reset defaults of rc0/rc1
    m_cfg.mirror_en = 1'b0;
    m_cfg.a_dis = 1'b0;
    m_cfg.b_dis = 1'b0;
    exp_a = idle;
    exp_b = idle;
    exp_alert = 1'b1;
    exp_cnt = '0;

    wait_reset_state();
    check_outputs();
    @(posedge ck_t);
    rst_n <= 1'b1;                 // second reset edge
    predict(idle);
    report_test("reset_values");

    repeat (200)
      cmd_step(rand_cmd());
    cmd_step(idle);
    report_test("pass_through");

    write_cw(RC0_ADDR, 4'b0011);
    repeat (50)
      cmd_step(rand_cmd());
    write_cw(RC0_ADDR, 4'b0001);
    cmd_step(idle);
    report_test("mirroring");

    repeat (15)
      bad_pair(1'b1);
    repeat (10)
      bad_pair(1'b0);
    write_cw(RC0_ADDR, 4'b0000);   // checking off
    repeat (15)
      bad_pair(1'b1);
    write_cw(RC0_ADDR, 4'b0001);
    cmd_step(idle);
    report_test("parity_error");

    write_cw(RC1_ADDR, 4'b0001);
    repeat (30)
      cmd_step(rand_cmd());
    write_cw(RC1_ADDR, 4'b0010);
    repeat (30)
      cmd_step(rand_cmd());
    write_cw(RC1_ADDR, 4'b0000);
    cmd_step(idle);
    report_test("output_disable");

    // writes land on the same edge as a command
    for (int i = 0; i < 80; i++)
    begin
      c = rand_cmd();
      if (i % 2 == 0 && $urandom_range(1) == 1)
        c.par = ~c.par;
      step(c, 1'($urandom_range(1)), CW_ADDR_W'($urandom_range(3)),
           CW_DATA_W'($urandom_range(15)));
    end
    write_cw(RC0_ADDR, 4'b0001);
    write_cw(RC1_ADDR, 4'b0000);
    cmd_step(idle);
    report_test("write_timing");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  initial
  begin
    #100000;
    $display("timeout: simulation did not reach its end in time");
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/rcd_assert.sv
// rcd alert and blocking rules
`timescale 1ns/10ps
`default_nettype none

module rcd_assert #(
  parameter int CS_NUM = 2
) (
  input logic                      ck_t,
  input logic                      rst_n,
  input logic                      alert_n,
  input logic [CS_NUM-1:0]         qa_cs_n,
  input logic [CS_NUM-1:0]         qb_cs_n,
  input logic [rcd_pkg::CNT_W-1:0] par_err_cnt
);

  // one error gives exactly one low cycle
  a_alert_pulse: assert property (@(posedge ck_t) disable iff (!rst_n)
    !alert_n |=> alert_n)
    else $error("alert_n held low for two cycles");

  // the erroneous command never reaches the drams
  a_alert_block: assert property (@(posedge ck_t) disable iff (!rst_n)
    !alert_n |-> (&qa_cs_n && &qb_cs_n))
    else $error("chip select active while alert_n low");

  // counter only counts up or saturates
  a_cnt_mono: assert property (@(posedge ck_t) disable iff (!rst_n)
    par_err_cnt >= $past(par_err_cnt))
    else $error("par_err_cnt decreased");

endmodule

bind rdimm_rcd_top rcd_assert #(.CS_NUM(CS_NUM)) u_rcd_assert (
  .ck_t        (ck_t),
  .rst_n       (rst_n),
  .alert_n     (alert_n),
  .qa_cs_n     (qa_cs_n),
  .qb_cs_n     (qb_cs_n),
  .par_err_cnt (par_err_cnt)
);

`default_nettype wire

//--- hdl/rdimm_rcd_top.sv
// ddr4 rdimm register clock driver
`timescale 1ns/10ps
`default_nettype none

module rdimm_rcd_top #(
  parameter int CS_NUM = 2 // chip selects, 1 to 4
) (
  input  logic                          ck_t,
  input  logic                          rst_n,
  input  logic                          act_n,
  input  logic [rcd_pkg::ADDR_W-1:0]    addr,
  input  logic [rcd_pkg::BA_W-1:0]      ba,
  input  logic [rcd_pkg::BG_W-1:0]      bg,
  input  logic                          par,
  input  logic [rcd_pkg::CKE_W-1:0]     cke,
  input  logic [rcd_pkg::ODT_W-1:0]     odt,
  input  logic [CS_NUM-1:0]             cs_n,
  input  logic                          cw_we,
  input  logic [rcd_pkg::CW_ADDR_W-1:0] cw_addr,
  input  logic [rcd_pkg::CW_DATA_W-1:0] cw_data,
  output logic                          qa_act_n,
  output logic [rcd_pkg::ADDR_W-1:0]    qa_addr,
  output logic [rcd_pkg::BA_W-1:0]      qa_ba,
  output logic [rcd_pkg::BG_W-1:0]      qa_bg,
  output logic                          qa_par,
  output logic [rcd_pkg::CKE_W-1:0]     qa_cke,
  output logic [rcd_pkg::ODT_W-1:0]     qa_odt,
  output logic [CS_NUM-1:0]             qa_cs_n,
  output logic                          qb_act_n,
  output logic [rcd_pkg::ADDR_W-1:0]    qb_addr,
  output logic [rcd_pkg::BA_W-1:0]      qb_ba,
  output logic [rcd_pkg::BG_W-1:0]      qb_bg,
  output logic                          qb_par,
  output logic [rcd_pkg::CKE_W-1:0]     qb_cke,
  output logic [rcd_pkg::ODT_W-1:0]     qb_odt,
  output logic [CS_NUM-1:0]             qb_cs_n,
  output logic                          alert_n,
  output logic [rcd_pkg::CNT_W-1:0]     par_err_cnt
);
  import rcd_pkg::*;

  rcd_cfg_t cfg;     // decoded control words
  logic     par_err; // bad command, blocks both sides

  ca_if #(.CS_NUM(CS_NUM)) ca_bus ();

  // controller side bus into the interface
  assign ca_bus.act_n = act_n;
  assign ca_bus.addr  = addr;
  assign ca_bus.ba    = ba;
  assign ca_bus.bg    = bg;
  assign ca_bus.par   = par;
  assign ca_bus.cke   = cke;
  assign ca_bus.odt   = odt;
  assign ca_bus.cs_n  = cs_n;

  rcd_ctrl_words u_ctrl_words (
    .ck_t    (ck_t),
    .rst_n   (rst_n),
    .cw_we   (cw_we),
    .cw_addr (cw_addr),
    .cw_data (cw_data),
    .cfg     (cfg)
  );

  rcd_parity_check #(.CS_NUM(CS_NUM)) u_parity_check (
    .ck_t    (ck_t),
    .rst_n   (rst_n),
    .ca      (ca_bus),
    .par_en  (cfg.par_en),
    .par_err (par_err),
    .alert_n (alert_n),
    .err_cnt (par_err_cnt)
  );

  // side a is never mirrored
  rcd_side_driver #(.CS_NUM(CS_NUM)) u_side_a (
    .ck_t      (ck_t),
    .rst_n     (rst_n),
    .ca        (ca_bus),
    .par_err   (par_err),
    .mirror_en (1'b0),
    .out_dis   (cfg.a_dis),
    .q_act_n   (qa_act_n),
    .q_addr    (qa_addr),
    .q_ba      (qa_ba),
    .q_bg      (qa_bg),
    .q_par     (qa_par),
    .q_cke     (qa_cke),
    .q_odt     (qa_odt),
    .q_cs_n    (qa_cs_n)
  );

  rcd_side_driver #(.CS_NUM(CS_NUM)) u_side_b (
    .ck_t      (ck_t),
    .rst_n     (rst_n),
    .ca        (ca_bus),
    .par_err   (par_err),
    .mirror_en (cfg.mirror_en), // rc0 mirror bit
    .out_dis   (cfg.b_dis),
    .q_act_n   (qb_act_n),
    .q_addr    (qb_addr),
    .q_ba      (qb_ba),
    .q_bg      (qb_bg),
    .q_par     (qb_par),
    .q_cke     (qb_cke),
    .q_odt     (qb_odt),
    .q_cs_n    (qb_cs_n)
  );

endmodule

`default_nettype wire

//--- rcd/rcd_side_driver.sv
// rcd output register for one side
`timescale 1ns/10ps
`default_nettype none

module rcd_side_driver #(
  parameter int CS_NUM = 2
) (
  input  logic                       ck_t,
  input  logic                       rst_n,
  ca_if.sink                         ca,
  input  logic                       par_err,   // block this command
  input  logic                       mirror_en, // swap address pairs
  input  logic                       out_dis,   // side turned off
  output logic                       q_act_n,
  output logic [rcd_pkg::ADDR_W-1:0] q_addr,
  output logic [rcd_pkg::BA_W-1:0]   q_ba,
  output logic [rcd_pkg::BG_W-1:0]   q_bg,
  output logic                       q_par,
  output logic [rcd_pkg::CKE_W-1:0]  q_cke,
  output logic [rcd_pkg::ODT_W-1:0]  q_odt,
  output logic [CS_NUM-1:0]          q_cs_n
);
  import rcd_pkg::*;

  logic [ADDR_W-1:0] addr_m; // after optional mirror
  logic [BA_W-1:0]   ba_m;
  logic [BG_W-1:0]   bg_m;
  logic              block;

  assign block = par_err | out_dis;

  // mirrored pairs keep the bit count, parity unchanged
  always_comb
  begin
    addr_m = ca.addr;
    ba_m   = ca.ba;
    bg_m   = ca.bg;
    if (mirror_en)
    begin
      addr_m[3]  = ca.addr[4];
      addr_m[4]  = ca.addr[3];
      addr_m[5]  = ca.addr[6];
      addr_m[6]  = ca.addr[5];
      addr_m[7]  = ca.addr[8];
      addr_m[8]  = ca.addr[7];
      addr_m[11] = ca.addr[13];
      addr_m[13] = ca.addr[11];
      ba_m       = {ca.ba[0], ca.ba[1]};
      bg_m       = {ca.bg[0], ca.bg[1]};
    end
  end

  // one cycle pipeline, new command every edge
  always_ff @(posedge ck_t)
  begin
    if (!rst_n)
    begin
      q_act_n <= 1'b1;
      q_addr  <= '0;
      q_ba    <= '0;
      q_bg    <= '0;
      q_par   <= 1'b0;
      q_cke   <= '0;  // drams held in power down
      q_odt   <= '0;
      q_cs_n  <= '1;  // no rank selected
    end
    else
    begin
      q_act_n <= ca.act_n | block; // blocked looks like a deselect
      q_addr  <= addr_m;
      q_ba    <= ba_m;
      q_bg    <= bg_m;
      q_par   <= ca.par;
      q_cke   <= ca.cke;           // cke follows even when blocked
      q_odt   <= ca.odt;
      q_cs_n  <= block ? '1 : ca.cs_n;
    end
  end

endmodule

`default_nettype wire

//--- rcd/rcd_parity_check.sv
// command parity check
`timescale 1ns/10ps
`default_nettype none

module rcd_parity_check #(
  parameter int CS_NUM = 2
) (
  input  logic                      ck_t,
  input  logic                      rst_n,
  ca_if.sink                        ca,
  input  logic                      par_en,  // from rc0
  output logic                      par_err, // current command is bad
  output logic                      alert_n, // one cycle low per error
  output logic [rcd_pkg::CNT_W-1:0] err_cnt
);
  import rcd_pkg::*;

  logic [CS_NUM-1:0] cs_n_w;
  logic              cmd_valid;
  logic              par_odd;
  logic              cnt_max;

  assign cs_n_w    = ca.cs_n;
  assign cmd_valid = ~&cs_n_w; // any rank selected

  // even parity: par must equal xor of the rest
  assign par_odd = ^{ca.act_n, ca.addr, ca.ba, ca.bg, ca.par};

  // only valid commands with checking on
  assign par_err = par_en & cmd_valid & par_odd;

  assign cnt_max = &err_cnt; // saturate here

  // alert lines up with the blocked output cycle
  always_ff @(posedge ck_t)
  begin
    if (!rst_n)
      alert_n <= 1'b1;
    else
      alert_n <= ~par_err;
  end

  always_ff @(posedge ck_t)
  begin
    if (!rst_n)
      err_cnt <= '0;
    else if (par_err && !cnt_max)
      err_cnt <= err_cnt + 1'b1;
  end

endmodule

`default_nettype wire

//--- rcd/rcd_ctrl_words.sv
// rcd control words
`timescale 1ns/10ps
`default_nettype none

module rcd_ctrl_words (
  input  logic                          ck_t,
  input  logic                          rst_n,
  input  logic                          cw_we,   // write strobe
  input  logic [rcd_pkg::CW_ADDR_W-1:0] cw_addr,
  input  logic [rcd_pkg::CW_DATA_W-1:0] cw_data,
  output rcd_pkg::rcd_cfg_t             cfg
);
  import rcd_pkg::*;

  logic [CW_DATA_W-1:0] rc0_q; // global setup
  logic [CW_DATA_W-1:0] rc1_q; // output disable
  logic                 rc0_wr;
  logic                 rc1_wr;

  // address decode, other addresses dropped
  assign rc0_wr = cw_we && (cw_addr == RC0_ADDR);
  assign rc1_wr = cw_we && (cw_addr == RC1_ADDR);

  // new value visible from the next edge
  always_ff @(posedge ck_t)
  begin
    if (!rst_n)
    begin
      rc0_q <= RC0_RST;
      rc1_q <= RC1_RST;
    end
    else
    begin
      if (rc0_wr)
        rc0_q <= cw_data; // upper bits reserved, held as written
      if (rc1_wr)
        rc1_q <= cw_data;
    end
  end

  assign cfg.par_en    = rc0_q[RC0_PAR_EN_BIT];
  assign cfg.mirror_en = rc0_q[RC0_MIRROR_BIT];
  assign cfg.a_dis     = rc1_q[RC1_A_DIS_BIT];
  assign cfg.b_dis     = rc1_q[RC1_B_DIS_BIT];

endmodule

`default_nettype wire

//--- common/ca_if.sv
// command/address bus
`timescale 1ns/10ps
`default_nettype none

interface ca_if #(
  parameter int CS_NUM = 2 // chip selects
) ();
  import rcd_pkg::*;

  logic              act_n; // activate, low active
  logic [ADDR_W-1:0] addr;
  logic [BA_W-1:0]   ba;
  logic [BG_W-1:0]   bg;
  logic              par;   // even parity from controller
  logic [CKE_W-1:0]  cke;
  logic [ODT_W-1:0]  odt;
  logic [CS_NUM-1:0] cs_n;  // any low marks a valid command

  // top level loads the bus
  modport src (
    output act_n, addr, ba, bg, par, cke, odt, cs_n
  );

  // parity checker and side drivers
  modport sink (
    input act_n, addr, ba, bg, par, cke, odt, cs_n
  );

endinterface

`default_nettype wire

//--- common/rcd_pkg.sv
// rcd shared definitions
`default_nettype none

package rcd_pkg;

  localparam int ADDR_W = 18; // da / qxa address bits
  localparam int BA_W   = 2;  // bank address
  localparam int BG_W   = 2;  // bank group
  localparam int CKE_W  = 2;  // clock enables
  localparam int ODT_W  = 2;  // odt pins
  localparam int CNT_W  = 8;  // saturating parity error count

  localparam int CW_ADDR_W = 4; // control word address bits
  localparam int CW_DATA_W = 4; // control word data bits

  localparam logic [CW_ADDR_W-1:0] RC0_ADDR = 4'h0; // global setup word
  localparam logic [CW_ADDR_W-1:0] RC1_ADDR = 4'h1; // output disable word

  // bit positions inside the words
  localparam int RC0_PAR_EN_BIT = 0; // parity check enable
  localparam int RC0_MIRROR_BIT = 1; // side b address mirror
  localparam int RC1_A_DIS_BIT  = 0; // side a outputs off
  localparam int RC1_B_DIS_BIT  = 1; // side b outputs off

  localparam logic [CW_DATA_W-1:0] RC0_RST = 4'b0001; // parity on, no mirror
  localparam logic [CW_DATA_W-1:0] RC1_RST = 4'b0000; // both sides on

  // decoded configuration seen by the datapath
  typedef struct packed {
    logic par_en;    // check parity on valid commands
    logic mirror_en; // swap side b address pairs
    logic a_dis;     // block side a
    logic b_dis;     // block side b
  } rcd_cfg_t;

endpackage

`default_nettype wire
